// ==== adc_packet_rx.f ====
hdl/pixel_pkg.sv
hdl/sample_capture.sv
hdl/row_buffer.sv
hdl/readout_ctrl.sv
hdl/packet_former.sv
hdl/adc_packet_rx.sv
bench/tb_adc_packet_rx.sv

// ==== bench/tb_adc_packet_rx.sv ====
`timescale 1ns/1ps

module tb_adc_packet_rx;
    import pixel_pkg::*;

    localparam int n_tests = 5;

    typedef struct packed {
        roi_t        roi;
        logic        load_roi;
        logic [15:0] base;
        logic [6:0]  stall;
        logic        extra;
    } test_entry_t;

    logic      CLK = 1'b0;
    logic      rst;
    logic      cnv;
    adc_row_t  adc_data;
    logic      set_param;
    roi_t      roi_in;
    logic      out_ready;
    out_word_t out_word;
    logic      out_valid;
    logic      frame_end;

    test_entry_t tests [n_tests];
    out_word_t   exp_q [$];
    roi_t        cur_roi;
    int          frame_no = 0;
    int          err_cnt = 0;
    int          failed = 0;
    int          cycles = 0;
    int          limit = 0;

    adc_packet_rx dut_i (
        .CLK       (CLK),
        .rst       (rst),
        .cnv       (cnv),
        .adc_data  (adc_data),
        .set_param (set_param),
        .roi_in    (roi_in),
        .out_ready (out_ready),
        .out_word  (out_word),
        .out_valid (out_valid),
        .frame_end (frame_end)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= limit)
        begin
            $display("Timeout: the run is still busy after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic roi_t make_roi(int rs, int re, int cs, int ce);
        roi_t r;
        r.row_start = row_w'(rs);
        r.row_end   = row_w'(re);
        r.col_start = col_w'(cs);
        r.col_end   = col_w'(ce);
        return r;
    endfunction

    // Header and footer around the pixels of the region
    function automatic int frame_words(roi_t r);
        return (int'(r.row_end) - int'(r.row_start) + 1) *
               (int'(r.col_end) - int'(r.col_start) + 1) + 2;
    endfunction

    function automatic adc_row_t make_row(logic [15:0] base, int r);
        adc_row_t d;
        for (int c = 0; c < n_channels; c++)
            d[c] = sample_t'(int'(base) + r * 16 + c);
        return d;
    endfunction

    function automatic adc_row_t junk_row();
        adc_row_t d;
        for (int c = 0; c < n_channels; c++)
            d[c] = sample_t'($urandom);
        return d;
    endfunction

    function automatic out_word_t make_word(word_kind_e kind, int r, int c, int d);
        out_word_t w;
        w      = '0;
        w.kind = kind;
        w.row  = row_w'(r);
        w.col  = col_w'(c);
        w.data = sample_t'(d);
        return w;
    endfunction

    task automatic add_test(int i, roi_t r, logic load, logic [15:0] base, int stall,
                            logic extra);
        tests[i] = '{roi: r, load_roi: load, base: base, stall: 7'(stall), extra: extra};
    endtask

    task automatic check_word(input string name, input out_word_t got, input out_word_t exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // Header carries the frame number, the footer the number of pixels sent
    task automatic build_expected(roi_t ro, logic [15:0] base);
        int n;
        n = 0;
        exp_q.delete();
        exp_q.push_back(make_word(kind_header, 0, 0, frame_no));
        for (int r = int'(ro.row_start); r <= int'(ro.row_end); r++)
        begin
            for (int c = int'(ro.col_start); c <= int'(ro.col_end); c++)
            begin
                exp_q.push_back(make_word(kind_signal, r, c, int'(base) + r * 16 + c));
                n++;
            end
        end
        exp_q.push_back(make_word(kind_footer, 0, 0, n));
    endtask

    task automatic pulse_param(roi_t r);
        @(posedge CLK);
        set_param <= 1'b1;
        roi_in    <= r;
        @(posedge CLK);
        set_param <= 1'b0;
    endtask

    // One strobe per row, then two idle cycles
    task automatic send_frame(logic [15:0] base);
        for (int r = 0; r < n_rows; r++)
        begin
            @(posedge CLK);
            cnv      <= 1'b1;
            adc_data <= make_row(base, r);
            @(posedge CLK);
            cnv <= 1'b0;
            @(posedge CLK);
        end
    endtask

    task automatic collect_frame(int stall, logic extra, int total);
        int        got;
        int        n;
        logic      pending;
        logic      held_fe;
        out_word_t held;
        out_word_t exp;
        got     = 0;
        n       = 0;
        pending = 1'b0;
        while (got < total)
        begin
            @(posedge CLK);
            out_ready <= (int'($urandom_range(99)) >= stall);
            // Extra strobes stay clear of the footer so the controller is still busy
            if (extra && got >= 1 && got < total - 2 && n % 3 == 0)
            begin
                cnv      <= 1'b1;
                adc_data <= junk_row();
            end
            else
                cnv <= 1'b0;
            n++;
            @(negedge CLK);
            if (!out_valid)
            begin
                check_bit("frame_end", frame_end, 1'b0);
                if (pending)
                begin
                    $display("ERROR at %0t: out_valid dropped before the word transferred",
                             $time);
                    err_cnt++;
                    pending = 1'b0;
                end
            end
            else
            begin
                if (pending)
                begin
                    check_word("held out_word", out_word, held);
                    check_bit("held frame_end", frame_end, held_fe);
                end
                if (out_ready)
                begin
                    exp = exp_q.pop_front();
                    check_word("out_word", out_word, exp);
                    check_bit("frame_end", frame_end, exp.kind == kind_footer);
                    got++;
                    pending = 1'b0;
                end
                else
                begin
                    pending = 1'b1;
                    held    = out_word;
                    held_fe = frame_end;
                end
            end
        end
        @(posedge CLK);
        cnv       <= 1'b0;
        out_ready <= 1'b0;
    endtask

    task automatic run_test(int i);
        int errs_before;
        int total;
        errs_before = err_cnt;
        if (tests[i].load_roi)
        begin
            pulse_param(tests[i].roi);
            cur_roi = tests[i].roi;
        end
        else
        begin
            // A new region on roi_in without set_param must not be taken
            @(posedge CLK);
            roi_in <= tests[i].roi;
        end
        build_expected(cur_roi, tests[i].base);
        total = exp_q.size();
        send_frame(tests[i].base);
        collect_frame(int'(tests[i].stall), tests[i].extra, total);
        frame_no++;
        if (err_cnt != errs_before)
            failed++;
        $display("Test %0d: %0d words, stall %0d%%, %0d errors", i, total,
                 tests[i].stall, err_cnt - errs_before);
    endtask

    initial
    begin
        roi_t lat;
        void'($urandom(32'h21b0255a));
        add_test(0, make_roi(0, 47, 0, 15), 1'b0, 16'h0000, 0, 1'b0);
        add_test(1, make_roi(3, 5, 2, 9), 1'b1, 16'h1234, 0, 1'b0);
        add_test(2, make_roi(0, 0, 0, 0), 1'b0, 16'hfff0, 60, 1'b0);
        add_test(3, make_roi(40, 47, 0, 15), 1'b1, 16'h8000, 25, 1'b1);
        add_test(4, make_roi(10, 11, 7, 10), 1'b1, 16'habcd, 60, 1'b1);
        cur_roi = make_roi(0, 47, 0, 15);
        lat     = cur_roi;
        limit   = 1000;
        for (int i = 0; i < n_tests; i++)
        begin
            if (tests[i].load_roi)
                lat = tests[i].roi;
            limit += 150 + 4 * frame_words(lat) * (1 + int'(tests[i].stall) / 25);
        end
        rst       = 1'b1;
        cnv       = 1'b0;
        adc_data  = '0;
        set_param = 1'b0;
        roi_in    = '0;
        out_ready = 1'b0;
        repeat (8) @(posedge CLK);
        rst <= 1'b0;
        @(negedge CLK);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("frame_end", frame_end, 1'b0);
        for (int i = 0; i < n_tests; i++)
            run_test(i);
        $display("%0d tests run, %0d failed, %0d errors", n_tests, failed, err_cnt);
        if (err_cnt == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== hdl/adc_packet_rx.sv ====
`timescale 1ns/1ps

module adc_packet_rx (
    input  logic                 CLK,
    input  logic                 rst,
    input  logic                 cnv,
    input  pixel_pkg::adc_row_t  adc_data,
    input  logic                 set_param,
    input  pixel_pkg::roi_t      roi_in,
    input  logic                 out_ready,
    output pixel_pkg::out_word_t out_word,
    output logic                 out_valid,
    output logic                 frame_end
);
    import pixel_pkg::*;

    row_write_t       row_wr;
    logic             frame_full;
    logic             capture_en;
    logic [row_w-1:0] rd_row;
    read_req_t        rd_req;
    adc_row_t         rd_data;
    logic             slot_free;

    sample_capture capture_i (
        .CLK        (CLK),
        .rst        (rst),
        .cnv        (cnv),
        .capture_en (capture_en),
        .adc_data   (adc_data),
        .row_wr     (row_wr),
        .frame_full (frame_full)
    );

    row_buffer buffer_i (
        .CLK     (CLK),
        .row_wr  (row_wr),
        .rd_row  (rd_row),
        .rd_data (rd_data)
    );

    readout_ctrl ctrl_i (
        .CLK        (CLK),
        .rst        (rst),
        .set_param  (set_param),
        .roi_in     (roi_in),
        .frame_full (frame_full),
        .slot_free  (slot_free),
        .capture_en (capture_en),
        .rd_row     (rd_row),
        .rd_req     (rd_req)
    );

    // The output side is the only block that sees out_ready
    packet_former former_i (
        .CLK       (CLK),
        .rst       (rst),
        .rd_req    (rd_req),
        .rd_data   (rd_data),
        .out_ready (out_ready),
        .out_word  (out_word),
        .out_valid (out_valid),
        .frame_end (frame_end),
        .slot_free (slot_free)
    );

endmodule

// ==== hdl/packet_former.sv ====
`timescale 1ns/1ps

module packet_former (
    input  logic                 CLK,
    input  logic                 rst,
    input  pixel_pkg::read_req_t rd_req,
    input  pixel_pkg::adc_row_t  rd_data,
    input  logic                 out_ready,
    output pixel_pkg::out_word_t out_word,
    output logic                 out_valid,
    output logic                 frame_end,
    output logic                 slot_free
);
    import pixel_pkg::*;

    read_req_t req_d;
    out_word_t next_word;

    // The request is delayed one cycle so that it lines up with the buffer read
    always_ff @(posedge CLK)
    begin
        if (rst)
            req_d.valid <= 1'b0;
        else
            req_d <= rd_req;
    end

    always_comb
    begin
        next_word.kind = req_d.kind;
        next_word.row  = req_d.row;
        next_word.col  = req_d.col;
        next_word.zero = '0;
        if (req_d.kind == kind_signal)
            next_word.data = rd_data[req_d.col];
        else
            next_word.data = req_d.payload;
    end

    // A new word only arrives once the held one has gone, so loading never
    // overwrites an unsent word
    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
            frame_end <= 1'b0;
        end
        else if (req_d.valid)
        begin
            out_valid <= 1'b1;
            frame_end <= (req_d.kind == kind_footer);
        end
        else if (out_valid && out_ready)
        begin
            out_valid <= 1'b0;
            frame_end <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req_d.valid)
            out_word <= next_word;
    end

    assign slot_free = !out_valid && !req_d.valid;

endmodule

// ==== hdl/pixel_pkg.sv ====
package pixel_pkg;

    // Frame geometry and word widths
    localparam int sample_w   = 16;
    localparam int n_channels = 16;
    localparam int n_rows     = 48;
    localparam int row_w      = 6;
    localparam int col_w      = 4;
    localparam int word_w     = 32;

    // Zero bits between the column field and the data field of an output word
    localparam int pad_w = word_w - 2 - row_w - col_w - sample_w;

    typedef logic [sample_w-1:0] sample_t;

    // Channel 0 sits in the lowest slot
    typedef sample_t [n_channels-1:0] adc_row_t;

    typedef struct packed {
        logic [row_w-1:0] row_start;
        logic [row_w-1:0] row_end;
        logic [col_w-1:0] col_start;
        logic [col_w-1:0] col_end;
    } roi_t;

    typedef struct packed {
        logic             wr;
        logic [row_w-1:0] row;
        adc_row_t         data;
    } row_write_t;

    // Code 0 is never sent
    typedef enum logic [1:0] {
        kind_header = 2'd1,
        kind_signal = 2'd2,
        kind_footer = 2'd3
    } word_kind_e;

    // Payload carries the frame count or the word count for header and footer words
    typedef struct packed {
        logic             valid;
        word_kind_e       kind;
        logic [row_w-1:0] row;
        logic [col_w-1:0] col;
        sample_t          payload;
    } read_req_t;

    typedef struct packed {
        word_kind_e       kind;
        logic [row_w-1:0] row;
        logic [col_w-1:0] col;
        logic [pad_w-1:0] zero;
        sample_t          data;
    } out_word_t;

    typedef enum logic [2:0] {
        st_capture,
        st_header,
        st_signal,
        st_footer,
        st_wait
    } ctrl_state_e;

endpackage

// ==== hdl/readout_ctrl.sv ====
`timescale 1ns/1ps

module readout_ctrl (
    input  logic                        CLK,
    input  logic                        rst,
    input  logic                        set_param,
    input  pixel_pkg::roi_t             roi_in,
    input  logic                        frame_full,
    input  logic                        slot_free,
    output logic                        capture_en,
    output logic [pixel_pkg::row_w-1:0] rd_row,
    output pixel_pkg::read_req_t        rd_req
);
    import pixel_pkg::*;

    ctrl_state_e      state;
    ctrl_state_e      ret_state;
    roi_t             roi;
    logic [row_w-1:0] row_idx;
    logic [col_w-1:0] col_idx;
    sample_t          frame_cnt;
    sample_t          word_cnt;
    logic             issue;
    logic             last_col;
    logic             last_pix;

    assign capture_en = (state == st_capture);
    assign rd_row     = row_idx;
    assign last_col   = (col_idx == roi.col_end);
    assign last_pix   = last_col && (row_idx == roi.row_end);

    // Requests wait for slot_free so that at most one word is in flight
    assign issue = slot_free &&
                   (state == st_header || state == st_signal || state == st_footer);

    always_comb
    begin
        rd_req       = '0;
        rd_req.valid = issue;
        rd_req.kind  = kind_signal;
        case (state)
            st_header:
            begin
                rd_req.kind    = kind_header;
                rd_req.payload = frame_cnt;
            end
            st_footer:
            begin
                rd_req.kind    = kind_footer;
                rd_req.payload = word_cnt;
            end
            default:
            begin
                rd_req.row = row_idx;
                rd_req.col = col_idx;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            state         <= st_capture;
            ret_state     <= st_signal;
            roi.row_start <= '0;
            roi.row_end   <= row_w'(n_rows - 1);
            roi.col_start <= '0;
            roi.col_end   <= col_w'(n_channels - 1);
            row_idx       <= '0;
            col_idx       <= '0;
            frame_cnt     <= '0;
            word_cnt      <= '0;
        end
        else
        begin
            case (state)
                st_capture:
                begin
                    if (set_param)
                        roi <= roi_in;
                    if (frame_full)
                        state <= st_header;
                end
                st_header:
                begin
                    if (issue)
                    begin
                        row_idx   <= roi.row_start;
                        col_idx   <= roi.col_start;
                        word_cnt  <= '0;
                        ret_state <= st_signal;
                        state     <= st_wait;
                    end
                end
                st_signal:
                begin
                    if (issue)
                    begin
                        word_cnt <= word_cnt + 1'b1;
                        // Columns inner, rows outer
                        if (last_col)
                        begin
                            col_idx <= roi.col_start;
                            row_idx <= row_idx + 1'b1;
                        end
                        else
                            col_idx <= col_idx + 1'b1;
                        ret_state <= last_pix ? st_footer : st_signal;
                        state     <= st_wait;
                    end
                end
                st_footer:
                begin
                    if (issue)
                    begin
                        frame_cnt <= frame_cnt + 1'b1;
                        state     <= st_capture;
                    end
                end
                st_wait:
                    state <= ret_state;
                default:
                    state <= st_capture;
            endcase
        end
    end

endmodule

// ==== hdl/row_buffer.sv ====
`timescale 1ns/1ps

module row_buffer (
    input  logic                          CLK,
    input  pixel_pkg::row_write_t         row_wr,
    input  logic [pixel_pkg::row_w-1:0]   rd_row,
    output pixel_pkg::adc_row_t           rd_data
);
    import pixel_pkg::*;

    // One full row of all channels per entry
    adc_row_t mem [n_rows];

    always_ff @(posedge CLK)
    begin
        if (row_wr.wr)
            mem[row_wr.row] <= row_wr.data;
    end

    // The read is registered so data follows the address by one cycle
    always_ff @(posedge CLK)
    begin
        rd_data <= mem[rd_row];
    end

endmodule

// ==== hdl/sample_capture.sv ====
`timescale 1ns/1ps

module sample_capture (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  cnv,
    input  logic                  capture_en,
    input  pixel_pkg::adc_row_t   adc_data,
    output pixel_pkg::row_write_t row_wr,
    output logic                  frame_full
);
    import pixel_pkg::*;

    logic [row_w-1:0] row_cnt;
    logic             wr_q;
    logic [row_w-1:0] row_q;
    adc_row_t         data_q;
    logic             accept;
    logic             last_row;

    // A strobe right behind the last row would land after the controller has
    // already committed to readout, so it is dropped while frame_full is up
    assign accept   = cnv && capture_en && !frame_full;
    assign last_row = (row_cnt == row_w'(n_rows - 1));

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            row_cnt    <= '0;
            wr_q       <= 1'b0;
            frame_full <= 1'b0;
        end
        else
        begin
            wr_q       <= accept;
            frame_full <= accept && last_row;
            if (accept)
                row_cnt <= last_row ? '0 : row_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            row_q  <= row_cnt;
            data_q <= adc_data;
        end
    end

    assign row_wr = '{wr: wr_q, row: row_q, data: data_q};

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f adc_packet_rx.f --top-module tb_adc_packet_rx -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1
